// File: source/snow_pkg.sv
/*
 * snowball shared definitions
 * address field widths, tlb entry layout, memory word views, cpu opcodes
 */
package snow_pkg;

  // --------------------------------------------------
  // address fields
  // --------------------------------------------------
  localparam int addr_w     = 32;   // word address
  localparam int data_w     = 32;
  localparam int page_w     = 16;   // virtual and physical page numbers
  localparam int tlb_idx_w  = 8;    // address bits 15..8
  localparam int line_idx_w = 8;    // address bits 7..0, bit 0 picks the word
  localparam int ctag_w     = page_w + tlb_idx_w;   // phys page + tlb index

  // --------------------------------------------------
  // translation entry and the word that carries it
  // --------------------------------------------------
  typedef struct packed {
    logic [page_w-1:0] phys_page;   // upper half
    logic [page_w-1:0] virt_page;   // lower half, checked on lookup
  } tlb_entry_t;

  // one cpu data word, either plain data or a tlb entry
  typedef union packed {
    logic [data_w-1:0] raw;
    tlb_entry_t        entry;
  } mem_word_u;

  // --------------------------------------------------
  // cpu request opcodes
  // --------------------------------------------------
  typedef enum logic [1:0] {
    op_read      = 2'd0,
    op_write     = 2'd1,
    op_tlb_write = 2'd2
  } cpu_op_e;

endpackage

// File: source/cache_ram.sv
/*
 * cache ram
 * synchronous-read array with one read and one write port
 */
`timescale 1ns/1ns

module cache_ram
  #(parameter int words = 256,
    parameter int width = 32)
  (
   input  logic                     CPU_CLK,
   input  logic                     re,
   input  logic [$clog2(words)-1:0] raddr,
   output logic [width-1:0]         rdata,
   input  logic                     we,
   input  logic [$clog2(words)-1:0] waddr,
   input  logic [width-1:0]         wdata
  );

  logic [width-1:0] mem [words];

  // block ram comes up cleared, so valid bits start at zero
  initial
  begin
    for (int i = 0; i < words; i++)
      mem[i] = '0;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
    if (re)
      rdata <= mem[raddr];   // holds last read when re is low
  end

endmodule

// File: source/tlb_unit.sv
/*
 * tlb unit
 * direct-mapped translation store, virtual to physical page with fault check
 */
`timescale 1ns/1ns

module tlb_unit
  #(parameter int entries = 256)
  (
   input  logic                           CPU_CLK,
   input  logic                           RST,
   input  logic                           look,
   input  logic [snow_pkg::addr_w-1:0]    vaddr,
   input  logic                           vmem_act,
   input  logic                           wr,
   input  logic [snow_pkg::tlb_idx_w-1:0] wr_idx,
   input  snow_pkg::mem_word_u            wr_entry,
   output logic [snow_pkg::page_w-1:0]    phys_page,
   output logic                           fault
  );

  import snow_pkg::*;

  mem_word_u         rd_word;   // entry read for the current lookup
  logic              vmem_q;    // translation on for this lookup
  logic [page_w-1:0] vpage_q;   // requested virtual page

  cache_ram #(.words(entries), .width(data_w)) tlb_ram
    (
     .CPU_CLK (CPU_CLK),
     .re      (look),
     .raddr   (vaddr[line_idx_w +: tlb_idx_w]),
     .rdata   (rd_word),
     .we      (wr),
     .waddr   (wr_idx),
     .wdata   (wr_entry.raw)
    );

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      vmem_q <= 1'b0;
    else if (look)
      vmem_q <= vmem_act;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (look)
      vpage_q <= vaddr[addr_w-1 -: page_w];
  end

  // untranslated requests pass the virtual page straight through
  assign phys_page = vmem_q ? rd_word.entry.phys_page : vpage_q;
  assign fault     = vmem_q && (rd_word.entry.virt_page != vpage_q);

endmodule

// File: source/cache_ctrl.sv
/*
 * cache controller
 * direct-mapped, two-word blocks, write-through; hit test, block fill,
 * inhibited bypass, and master side of the memory bus
 */
`timescale 1ns/1ns

module cache_ctrl
  #(parameter int cache_words = 256)
  (
   input  logic                           CPU_CLK,
   input  logic                           RST,
   input  logic                           cpu_valid,
   output logic                           cpu_ready,
   input  snow_pkg::cpu_op_e              cpu_op,
   input  logic [snow_pkg::addr_w-1:0]    cpu_addr,
   input  logic [snow_pkg::data_w-1:0]    cpu_wdata,
   input  logic                           cpu_inhibit,
   output logic                           rsp_valid,
   output logic [snow_pkg::data_w-1:0]    rsp_rdata,
   output logic                           rsp_fault,
   output logic                           tlb_look,
   output logic [snow_pkg::addr_w-1:0]    tlb_vaddr,
   output logic                           tlb_wr,
   output logic [snow_pkg::tlb_idx_w-1:0] tlb_wr_idx,
   output snow_pkg::mem_word_u            tlb_wr_entry,
   input  logic [snow_pkg::page_w-1:0]    phys_page,
   input  logic                           tlb_fault,
   output logic                           cc_req_valid,
   output logic                           cc_req_lock,
   output logic                           cc_req_we,
   output logic [snow_pkg::addr_w-1:0]    cc_req_addr,
   output logic [snow_pkg::data_w-1:0]    cc_req_wdata,
   input  logic                           cc_ready,
   input  logic [snow_pkg::data_w-1:0]    cc_rdata
  );

  import snow_pkg::*;

  localparam logic [2:0] s_idle  = 3'd0;
  localparam logic [2:0] s_look  = 3'd1;   // arrays and tlb valid here
  localparam logic [2:0] s_fill0 = 3'd2;   // requested word
  localparam logic [2:0] s_fill1 = 3'd3;   // its neighbour
  localparam logic [2:0] s_mem   = 3'd4;   // write-through or bypass read

  logic [2:0]        state;
  cpu_op_e           op_q;
  logic [addr_w-1:0] addr_q, paddr_q;
  logic [data_w-1:0] wdata_q, data_rd, ram_wdata;
  logic [ctag_w-1:0] tag_rd;
  logic              inhibit_q, hit_q, valid_rd, hit, accept, ram_we;

  assign accept    = cpu_valid && cpu_ready;
  assign cpu_ready = (state == s_idle);

  // --------------------------------------------------
  // tlb side
  // --------------------------------------------------
  assign tlb_look     = accept;
  assign tlb_vaddr    = cpu_addr;
  assign tlb_wr       = (state == s_look) && (op_q == op_tlb_write);
  assign tlb_wr_idx   = addr_q[line_idx_w +: tlb_idx_w];
  assign tlb_wr_entry = mem_word_u'(wdata_q);   // data word holds the entry

  assign hit = valid_rd && (tag_rd == {phys_page, addr_q[line_idx_w +: tlb_idx_w]});

  // --------------------------------------------------
  // memory bus master
  // --------------------------------------------------
  assign cc_req_valid = (state == s_fill0) || (state == s_fill1) || (state == s_mem);
  assign cc_req_lock  = (state == s_fill0) || (state == s_fill1);
  assign cc_req_we    = (state == s_mem) && (op_q == op_write);
  assign cc_req_addr  = {paddr_q[addr_w-1:1], paddr_q[0] ^ (state == s_fill1)};
  assign cc_req_wdata = wdata_q;

  // fill beats and write hits land in the arrays at the beat's own index
  assign ram_we    = cc_ready && (cc_req_lock || ((state == s_mem) && hit_q));
  assign ram_wdata = (state == s_mem) ? wdata_q : cc_rdata;

  cache_ram #(.words(cache_words), .width(data_w)) data_ram
    (.CPU_CLK(CPU_CLK), .re(accept), .raddr(cpu_addr[line_idx_w-1:0]), .rdata(data_rd),
     .we(ram_we), .waddr(cc_req_addr[line_idx_w-1:0]), .wdata(ram_wdata));

  cache_ram #(.words(cache_words), .width(ctag_w)) tag_ram
    (.CPU_CLK(CPU_CLK), .re(accept), .raddr(cpu_addr[line_idx_w-1:0]), .rdata(tag_rd),
     .we(ram_we), .waddr(cc_req_addr[line_idx_w-1:0]), .wdata(paddr_q[addr_w-1:line_idx_w]));

  cache_ram #(.words(cache_words), .width(1)) valid_ram
    (.CPU_CLK(CPU_CLK), .re(accept), .raddr(cpu_addr[line_idx_w-1:0]), .rdata(valid_rd),
     .we(ram_we), .waddr(cc_req_addr[line_idx_w-1:0]), .wdata(1'b1));

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state     <= s_idle;
      rsp_valid <= 1'b0;
      rsp_fault <= 1'b0;
    end
    else
    begin
      rsp_valid <= 1'b0;   // one cycle pulse
      case (state)
        s_idle:
          if (accept)
            state <= s_look;
        s_look:
          if ((op_q == op_tlb_write) || tlb_fault)
          begin
            rsp_valid <= 1'b1;   // no memory beat either way
            rsp_fault <= tlb_fault && (op_q != op_tlb_write);
            state     <= s_idle;
          end
          else if ((op_q == op_read) && !inhibit_q)
          begin
            if (hit)
            begin
              rsp_valid <= 1'b1;
              rsp_fault <= 1'b0;
              state     <= s_idle;
            end
            else
              state <= s_fill0;
          end
          else
            state <= s_mem;
        s_fill0:
          if (cc_ready)
            state <= s_fill1;
        s_fill1, s_mem:
          if (cc_ready)
          begin
            rsp_valid <= 1'b1;
            rsp_fault <= 1'b0;
            state     <= s_idle;
          end
        default:
          state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      op_q      <= cpu_op;
      addr_q    <= cpu_addr;
      wdata_q   <= cpu_wdata;
      inhibit_q <= cpu_inhibit;
    end
    if (state == s_look)
    begin
      paddr_q   <= {phys_page, addr_q[addr_w-page_w-1:0]};
      hit_q     <= hit && (op_q == op_write);   // write updates a present word
      rsp_rdata <= data_rd;
    end
    else if (cc_ready && (state != s_fill1) && !cc_req_we)
      rsp_rdata <= cc_rdata;   // requested word of a fill or bypass read
  end

endmodule

// File: source/mem_arbiter.sv
/*
 * memory arbiter
 * round-robin between cache controller and dma port onto one memory bus
 */
`timescale 1ns/1ns

module mem_arbiter
  (
   input  logic                        CPU_CLK,
   input  logic                        RST,
   input  logic                        cc_req_valid,
   input  logic                        cc_req_lock,
   input  logic                        cc_req_we,
   input  logic [snow_pkg::addr_w-1:0] cc_req_addr,
   input  logic [snow_pkg::data_w-1:0] cc_req_wdata,
   output logic                        cc_ready,
   input  logic                        dma_req_valid,
   input  logic                        dma_req_we,
   input  logic [snow_pkg::addr_w-1:0] dma_req_addr,
   input  logic [snow_pkg::data_w-1:0] dma_req_wdata,
   output logic                        dma_ready,
   output logic                        mem_valid,
   output logic                        mem_we,
   output logic [snow_pkg::addr_w-1:0] mem_addr,
   output logic [snow_pkg::data_w-1:0] mem_wdata,
   input  logic                        mem_ready,
   input  logic [snow_pkg::data_w-1:0] mem_rdata,
   output logic [snow_pkg::data_w-1:0] rdata_out
  );

  logic grant_cc, last_cc, lock_q, hold_q, held_cc, cc_done;

  // --------------------------------------------------
  // grant: stalled beat, then fill lock, then round robin
  // --------------------------------------------------
  assign grant_cc = hold_q ? held_cc :
                    lock_q ? 1'b1 :
                    (cc_req_valid && dma_req_valid) ? !last_cc : cc_req_valid;

  assign mem_valid = grant_cc ? cc_req_valid : dma_req_valid;
  assign mem_we    = grant_cc ? cc_req_we    : dma_req_we;
  assign mem_addr  = grant_cc ? cc_req_addr  : dma_req_addr;
  assign mem_wdata = grant_cc ? cc_req_wdata : dma_req_wdata;

  assign cc_ready  = grant_cc && cc_req_valid && mem_ready;
  assign dma_ready = !grant_cc && dma_req_valid && mem_ready;
  assign rdata_out = mem_rdata;   // both masters see the read data
  assign cc_done   = cc_ready;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      last_cc <= 1'b0;
      lock_q  <= 1'b0;
      hold_q  <= 1'b0;
      held_cc <= 1'b0;
    end
    else
    begin
      hold_q  <= mem_valid && !mem_ready;   // keep owner while beat waits
      held_cc <= grant_cc;
      if (mem_valid && mem_ready)
        last_cc <= grant_cc;
      if (cc_done)
        lock_q <= cc_req_lock && !lock_q;   // set after beat one, clear after two
    end
  end

endmodule

// File: source/snowball_top.sv
/*
 * snowball top
 * tlb, cache controller and memory arbiter with the dma port
 */
`timescale 1ns/1ns

module snowball_top
  #(parameter int tlb_entries = 256,
    parameter int cache_words = 256)
  (
   input  logic                        CPU_CLK,
   input  logic                        RST,
   input  logic                        cpu_valid,
   output logic                        cpu_ready,
   input  snow_pkg::cpu_op_e           cpu_op,
   input  logic [snow_pkg::addr_w-1:0] cpu_addr,
   input  logic [snow_pkg::data_w-1:0] cpu_wdata,
   input  logic                        cpu_inhibit,
   input  logic                        vmem_act,
   output logic                        rsp_valid,
   output logic [snow_pkg::data_w-1:0] rsp_rdata,
   output logic                        rsp_fault,
   input  logic                        dma_valid,
   output logic                        dma_ready,
   input  logic                        dma_we,
   input  logic [snow_pkg::addr_w-1:0] dma_addr,
   input  logic [snow_pkg::data_w-1:0] dma_wdata,
   output logic [snow_pkg::data_w-1:0] dma_rdata,
   output logic                        mem_valid,
   output logic                        mem_we,
   output logic [snow_pkg::addr_w-1:0] mem_addr,
   output logic [snow_pkg::data_w-1:0] mem_wdata,
   input  logic                        mem_ready,
   input  logic [snow_pkg::data_w-1:0] mem_rdata
  );

  import snow_pkg::*;

  // --------------------------------------------------
  // controller to tlb
  // --------------------------------------------------
  logic                 tlb_look, tlb_wr, tlb_fault;
  logic [addr_w-1:0]    tlb_vaddr;
  logic [tlb_idx_w-1:0] tlb_wr_idx;
  mem_word_u            tlb_wr_entry;
  logic [page_w-1:0]    phys_page;

  // controller to arbiter
  logic                 cc_req_valid, cc_req_lock, cc_req_we, cc_ready;
  logic [addr_w-1:0]    cc_req_addr;
  logic [data_w-1:0]    cc_req_wdata;

  tlb_unit #(.entries(tlb_entries)) tlb0
    (.CPU_CLK(CPU_CLK), .RST(RST), .look(tlb_look), .vaddr(tlb_vaddr),
     .vmem_act(vmem_act), .wr(tlb_wr), .wr_idx(tlb_wr_idx), .wr_entry(tlb_wr_entry),
     .phys_page(phys_page), .fault(tlb_fault));

  cache_ctrl #(.cache_words(cache_words)) ctrl0
    (.CPU_CLK(CPU_CLK), .RST(RST), .cpu_valid(cpu_valid), .cpu_ready(cpu_ready),
     .cpu_op(cpu_op), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
     .cpu_inhibit(cpu_inhibit), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
     .rsp_fault(rsp_fault), .tlb_look(tlb_look), .tlb_vaddr(tlb_vaddr),
     .tlb_wr(tlb_wr), .tlb_wr_idx(tlb_wr_idx), .tlb_wr_entry(tlb_wr_entry),
     .phys_page(phys_page), .tlb_fault(tlb_fault), .cc_req_valid(cc_req_valid),
     .cc_req_lock(cc_req_lock), .cc_req_we(cc_req_we), .cc_req_addr(cc_req_addr),
     .cc_req_wdata(cc_req_wdata), .cc_ready(cc_ready), .cc_rdata(dma_rdata));

  // shared read data feeds the dma port and the controller
  mem_arbiter arb0
    (.CPU_CLK(CPU_CLK), .RST(RST), .cc_req_valid(cc_req_valid),
     .cc_req_lock(cc_req_lock), .cc_req_we(cc_req_we), .cc_req_addr(cc_req_addr),
     .cc_req_wdata(cc_req_wdata), .cc_ready(cc_ready), .dma_req_valid(dma_valid),
     .dma_req_we(dma_we), .dma_req_addr(dma_addr), .dma_req_wdata(dma_wdata),
     .dma_ready(dma_ready), .mem_valid(mem_valid), .mem_we(mem_we),
     .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
     .mem_rdata(mem_rdata), .rdata_out(dma_rdata));

endmodule

// File: dv/mem_model.sv
/*
 * testbench memory
 * word memory on the shared bus, ready delay supplied by the testbench
 */
`timescale 1ns/1ns

module mem_model
  (
   input  logic        CPU_CLK,
   input  logic        RST,
   input  logic        mem_valid,
   input  logic        mem_we,
   input  logic [31:0] mem_addr,
   input  logic [31:0] mem_wdata,
   output logic        mem_ready,
   output logic [31:0] mem_rdata,
   input  logic [1:0]  delay
  );

  logic [31:0] store [logic [31:0]];   // written words only
  logic [1:0]  wait_cnt;
  int          wr_seq = 0;             // bumps on every write so rdata re-evaluates

  // unwritten words read back a pattern of their own address
  function automatic logic [31:0] peek(input logic [31:0] a);
    if (store.exists(a))
      return store[a];
    return a ^ 32'h5a5a_5a5a;
  endfunction

  // change a word behind the cache
  task automatic poke(input logic [31:0] a, input logic [31:0] d);
    store[a] = d;
    wr_seq   = wr_seq + 1;
  endtask

  assign mem_ready = mem_valid && (wait_cnt == 2'd0);

  always @(mem_addr or wr_seq)
    mem_rdata = peek(mem_addr);

  always @(posedge CPU_CLK)
  begin
    if (!RST)
      wait_cnt <= 2'd0;
    else if (mem_valid && mem_ready)
    begin
      wait_cnt <= delay;   // delay of the next beat
      if (mem_we)
      begin
        store[mem_addr] = mem_wdata;
        wr_seq          = wr_seq + 1;
      end
    end
    else if (mem_valid && (wait_cnt != 2'd0))
      wait_cnt <= wait_cnt - 2'd1;
  end

endmodule

// File: dv/tb_snowball.sv
/*
 * snowball testbench
 * case file driven cpu requests, background dma traffic, bus monitor
 */
`timescale 1ns/1ns

module tb_snowball;

  import snow_pkg::*;

  localparam int timeout_cycles = 200;

  logic        CPU_CLK, RST;
  logic        cpu_valid, cpu_ready, cpu_inhibit, vmem_act;
  cpu_op_e     cpu_op;
  logic [31:0] cpu_addr, cpu_wdata;
  logic        rsp_valid, rsp_fault;
  logic [31:0] rsp_rdata;
  logic        dma_valid, dma_ready, dma_we;
  logic [31:0] dma_addr, dma_wdata, dma_rdata;
  logic        mem_valid, mem_we, mem_ready;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  logic [1:0]  mem_delay;

  logic [16:0] lfsr_q = 17'd93604;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          dma_count = 0;
  int          cpu_beats = 0;
  bit          cases_done = 0;
  bit          fill_read = 0;    // current request may fill a block
  bit          fill_open = 0;
  logic [31:0] fill_addr;

  initial
    CPU_CLK = 1'b0;
  always #4 CPU_CLK = ~CPU_CLK;

  snowball_top #(.tlb_entries(256), .cache_words(256)) dut0
    (.CPU_CLK(CPU_CLK), .RST(RST), .cpu_valid(cpu_valid), .cpu_ready(cpu_ready),
     .cpu_op(cpu_op), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
     .cpu_inhibit(cpu_inhibit), .vmem_act(vmem_act), .rsp_valid(rsp_valid),
     .rsp_rdata(rsp_rdata), .rsp_fault(rsp_fault), .dma_valid(dma_valid),
     .dma_ready(dma_ready), .dma_we(dma_we), .dma_addr(dma_addr),
     .dma_wdata(dma_wdata), .dma_rdata(dma_rdata), .mem_valid(mem_valid),
     .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
     .mem_ready(mem_ready), .mem_rdata(mem_rdata));

  mem_model mem0
    (.CPU_CLK(CPU_CLK), .RST(RST), .mem_valid(mem_valid), .mem_we(mem_we),
     .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
     .mem_rdata(mem_rdata), .delay(mem_delay));

  // --------------------------------------------------
  // random source, x^17 + x^14 + 1
  // --------------------------------------------------
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r      = {r[30:0], lfsr_q[16]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  always @(posedge CPU_CLK)
  begin
    #1;
    mem_delay = take_bits(2);   // 0..3 wait cycles
  end

  // --------------------------------------------------
  // bus monitor, dma region is page 00f0
  // --------------------------------------------------
  always @(negedge CPU_CLK)
  begin
    if (mem_valid && mem_ready)
    begin
      if (mem_addr[31:16] != 16'h00f0)
        cpu_beats++;
      if (fill_open)
      begin
        assert ((mem_addr[31:16] != 16'h00f0) && (mem_addr == (fill_addr ^ 32'd1)))
        else
        begin
          $display("block fill at %h was split by another beat at %h", fill_addr, mem_addr);
          errors++;
        end
        fill_open = 0;
      end
      else if ((mem_addr[31:16] != 16'h00f0) && !mem_we && fill_read)
      begin
        fill_open = 1;
        fill_addr = mem_addr;
      end
    end
  end

  task automatic cpu_request(input logic [127:0] name, input logic [1:0] op,
                             input logic inh, input logic vm,
                             input logic [31:0] a, input logic [31:0] d,
                             output logic [31:0] rd, output logic flt,
                             output int beats, output bit ok);
    int n;
    int start_beats;
    bit taken;
    ok = 0;
    rd = '0;
    flt = 1'b0;
    beats = 0;
    @(posedge CPU_CLK);
    #1;
    fill_read   = (op == 2'd0) && !inh;
    start_beats = cpu_beats;
    cpu_valid   = 1'b1;
    cpu_op      = cpu_op_e'(op);
    cpu_inhibit = inh;
    vmem_act    = vm;
    cpu_addr    = a;
    cpu_wdata   = d;
    n = 0;
    while (!cpu_ready && (n < timeout_cycles))
    begin
      @(negedge CPU_CLK);
      n++;
    end
    taken = cpu_ready;
    @(posedge CPU_CLK);
    #1;
    cpu_valid = 1'b0;
    if (!taken)
    begin
      $display("%0s timed out waiting for cpu_ready", name);
      errors++;
      return;
    end
    n = 0;
    while (!ok && (n < timeout_cycles))
    begin
      @(negedge CPU_CLK);
      if (rsp_valid)
      begin
        ok  = 1;
        rd  = rsp_rdata;
        flt = rsp_fault;
      end
      n++;
    end
    if (!ok)
    begin
      $display("%0s timed out waiting for rsp_valid", name);
      errors++;
    end
    beats = cpu_beats - start_beats;
  endtask

  task automatic dma_access(input logic we, input logic [31:0] a, input logic [31:0] d,
                            output logic [31:0] rd, output bit ok);
    int n;
    ok = 0;
    rd = '0;
    dma_valid = 1'b1;   // called 1 ns after an edge
    dma_we    = we;
    dma_addr  = a;
    dma_wdata = d;
    n = 0;
    while (!ok && (n < timeout_cycles))
    begin
      @(negedge CPU_CLK);
      if (dma_ready)
      begin
        ok = 1;
        rd = dma_rdata;
      end
      n++;
    end
    @(posedge CPU_CLK);
    #1;
    dma_valid = 1'b0;
  endtask

  task automatic dma_traffic();
    logic [31:0] a, d, rd;
    bit          ok;
    while (!cases_done)
    begin
      a = {24'h00f000, 8'(take_bits(8))};
      d = take_bits(32);
      dma_access(1'b1, a, d, rd, ok);
      if (ok)
        dma_access(1'b0, a, 32'd0, rd, ok);
      if (!ok)
      begin
        $display("dma access at %h timed out waiting for dma_ready", a);
        errors++;
        break;
      end
      assert (rd == d)
      else
      begin
        $display("ERR dma_readback expected %h actual %h", d, rd);
        errors++;
      end
      dma_count++;
      repeat (take_bits(2))
      begin
        @(posedge CPU_CLK);
        #1;
      end
    end
  endtask

  task automatic run_cases();
    int          fd, code, beats, err_before;
    string       line;
    logic [127:0] name;
    logic [3:0]  op;
    logic        inh, vm, exp_f, flt;
    logic [31:0] a, d, exp_d, rd;
    bit          ok;
    fd = $fopen("dv/snowball_cases.txt", "r");
    if (fd == 0)
    begin
      $display("case file dv/snowball_cases.txt could not be opened");
      errors++;
      return;
    end
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      if ((code == 0) || (line.len() < 2) || (line[0] == 8'h23))
        continue;
      code = $sscanf(line, "%s %h %h %h %h %h %h %h", name, op, inh, vm, a, d, exp_d, exp_f);
      if (code != 8)
        continue;
      err_before = errors;
      tests++;
      if (op == 4'd3)
        mem0.poke(a, d);   // memory changed behind the cache
      else if (op == 4'd4)
      begin
        rd = mem0.peek(a);
        assert (rd == exp_d)
        else
        begin
          $display("ERR %0s expected %h actual %h", name, exp_d, rd);
          errors++;
        end
      end
      else
      begin
        cpu_request(name, op[1:0], inh, vm, a, d, rd, flt, beats, ok);
        if (ok)
        begin
          assert (flt == exp_f)
          else
          begin
            $display("ERR %0s expected fault %0d actual %0d", name, exp_f, flt);
            errors++;
          end
          if ((op == 4'd0) && !exp_f)
            assert (rd == exp_d)
            else
            begin
              $display("ERR %0s expected %h actual %h", name, exp_d, rd);
              errors++;
            end
          if (exp_f)
            assert (beats == 0)
            else
            begin
              $display("%0s made %0d memory beats on a faulting request", name, beats);
              errors++;
            end
        end
      end
      if (errors != err_before)
        failed_tests++;
      $display("%0s %s", name, (errors == err_before) ? "ok" : "FAILED");
    end
    $fclose(fd);
    fill_read = 0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    RST         = 1'b0;
    cpu_valid   = 1'b0;
    cpu_op      = op_read;
    cpu_addr    = '0;
    cpu_wdata   = '0;
    cpu_inhibit = 1'b0;
    vmem_act    = 1'b0;
    dma_valid   = 1'b0;
    dma_we      = 1'b0;
    dma_addr    = '0;
    dma_wdata   = '0;
    mem_delay   = 2'd0;
    repeat (4) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;
    fork
      begin
        run_cases();
        cases_done = 1;
      end
      dma_traffic();
    join
    $display("tests %0d, failed %0d, dma pairs %0d, errors %0d",
             tests, failed_tests, dma_count, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: dv/snowball_cases.txt
# name op inhibit vmem addr data expected_data expected_fault (hex)
# op 0 read, 1 write, 2 tlb write, 3 memory poke, 4 memory check
rd_miss 0 0 0 00001234 00000000 5a5a486e 0
rd_hit 0 0 0 00001234 00000000 5a5a486e 0
rd_neighbor 0 0 0 00001235 00000000 5a5a486f 0
wr_miss 1 0 0 00002040 cafe0001 00000000 0
wr_miss_read 0 0 0 00002040 00000000 cafe0001 0
wr_miss_mem 4 0 0 00002040 00000000 cafe0001 0
wh_fill 0 0 0 00003010 00000000 5a5a6a4a 0
wh_write 1 0 0 00003010 beef0002 00000000 0
wh_read 0 0 0 00003010 00000000 beef0002 0
wh_mem 4 0 0 00003010 00000000 beef0002 0
tlb_load 2 0 0 00074520 00120007 00000000 0
xl_read 0 0 1 00074520 00000000 5a481f7a 0
xl_neighbor 0 0 1 00074521 00000000 5a481f7b 0
xl_fault 0 0 1 00084521 00000000 00000000 1
byp_fill 0 0 0 00005008 00000000 5a5a0a52 0
byp_poke 3 0 0 00005008 11112222 00000000 0
byp_inhibit 0 1 0 00005008 00000000 11112222 0
byp_cached 0 0 0 00005008 00000000 5a5a0a52 0
arb_miss0 0 0 0 00006100 00000000 5a5a3b5a 0
arb_miss1 0 0 0 00006203 00000000 5a5a3859 0
arb_miss2 0 0 0 0000a0ff 00000000 5a5afaa5 0
arb_miss3 0 0 0 0001c0c1 00000000 5a5b9a9b 0
evict_other 0 0 0 00009034 00000000 5a5aca6e 0
evict_back 0 0 0 00001234 00000000 5a5a486e 0

// File: build.f
source/snow_pkg.sv
source/cache_ram.sv
source/tlb_unit.sv
source/cache_ctrl.sv
source/mem_arbiter.sv
source/snowball_top.sv
dv/mem_model.sv
dv/tb_snowball.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the snowball testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_snowball -o sim_snowball

./obj_dir/sim_snowball | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
